// File: verilog/tlu_macros.svh
`ifndef TLU_MACROS_SVH
`define TLU_MACROS_SVH

// clock cycles per serial trigger-number bit, at least 4
`define TLU_DIVISOR 12

// event word payload width
`define TLU_PAYLOAD_W 31

// bit count used when the configured count is zero
`define TLU_BITS_DEFAULT 31

// free-running timestamp width
`define TLU_TS_W 31

`endif

// File: verilog/tlu_pkg.sv
`include "tlu_macros.svh"

package tlu_pkg;

    typedef enum logic {
        MODE_TRIGGER   = 1'b0,
        MODE_HANDSHAKE = 1'b1
    } tlu_mode_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        WAIT_LOW  = 3'd1,
        RECEIVE   = 3'd2,
        STORE     = 3'd3,
        WAIT_READ = 3'd4
    } tlu_state_t;

    // trigger number view, handshake mode
    typedef struct packed {
        logic                      valid;
        logic [`TLU_PAYLOAD_W-1:0] number;
    } tlu_trg_word_t;

    // timestamp view, trigger mode
    typedef struct packed {
        logic                 valid;
        logic [`TLU_TS_W-1:0] stamp;
    } tlu_ts_word_t;

    typedef union packed {
        tlu_trg_word_t trg;
        tlu_ts_word_t  ts;
    } tlu_event_t;

endpackage

// File: verilog/tlu_sequencer.sv
`include "tlu_macros.svh"

module tlu_sequencer (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      trigger,
    input  tlu_pkg::tlu_mode_t        mode,
    input  logic [7:0]                low_timeout,
    output logic                      busy,
    output logic                      start_flag,
    output logic                      timeout_error,
    output logic                      rx_start,
    input  logic                      rx_done,
    input  logic [`TLU_PAYLOAD_W-1:0] rx_payload,
    output logic                      evt_write,
    output tlu_pkg::tlu_event_t       evt_word,
    input  logic                      evt_full
);

    tlu_pkg::tlu_state_t  state;
    tlu_pkg::tlu_state_t  next_state;
    tlu_pkg::tlu_mode_t   mode_q;
    logic [`TLU_TS_W-1:0] ts_cnt;
    logic [`TLU_TS_W-1:0] ts_q;
    logic [7:0]           low_cnt;
    logic                 ready;
    logic                 accept;
    logic                 timeout_hit;
    logic                 leave_low;

    // a drained buffer lets WAIT_READ take a new trigger
    assign ready  = (state == tlu_pkg::IDLE) ||
                    ((state == tlu_pkg::WAIT_READ) && !evt_full);
    assign accept = ready && trigger;
    assign busy   = !ready;

    // low_cnt includes the current WAIT_LOW cycle
    assign timeout_hit = (state == tlu_pkg::WAIT_LOW) && (low_timeout != 8'd0) &&
                         (low_cnt == low_timeout);
    assign leave_low   = !trigger || timeout_hit;

    // receiver starts on the edge that leaves WAIT_LOW for RECEIVE
    assign rx_start  = (state == tlu_pkg::WAIT_LOW) && (next_state == tlu_pkg::RECEIVE);
    assign evt_write = (state == tlu_pkg::STORE);

    always_comb
    begin
        next_state = state;
        case (state)
            tlu_pkg::IDLE:
            begin
                if (accept)
                    next_state = tlu_pkg::WAIT_LOW;
            end
            tlu_pkg::WAIT_LOW:
            begin
                if (leave_low)
                begin
                    if (mode_q == tlu_pkg::MODE_HANDSHAKE)
                        next_state = tlu_pkg::RECEIVE;
                    else
                        next_state = tlu_pkg::STORE;
                end
            end
            tlu_pkg::RECEIVE:
            begin
                if (rx_done)
                    next_state = tlu_pkg::STORE;
            end
            tlu_pkg::STORE:
            begin
                next_state = tlu_pkg::WAIT_READ;
            end
            tlu_pkg::WAIT_READ:
            begin
                if (accept)
                    next_state = tlu_pkg::WAIT_LOW;
                else if (!evt_full)
                    next_state = tlu_pkg::IDLE;
            end
            default:
            begin
                next_state = tlu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= tlu_pkg::IDLE;
            mode_q        <= tlu_pkg::MODE_TRIGGER;
            start_flag    <= 1'b0;
            timeout_error <= 1'b0;
            low_cnt       <= 8'd0;
            ts_cnt        <= '0;
        end
        else
        begin
            state      <= next_state;
            start_flag <= accept;
            ts_cnt     <= ts_cnt + 1'b1;
            if (accept)
            begin
                mode_q        <= mode;
                low_cnt       <= 8'd1;
                timeout_error <= 1'b0;
            end
            else if (state == tlu_pkg::WAIT_LOW)
            begin
                low_cnt <= low_cnt + 8'd1;
                // sticky until the next accepted trigger
                if (timeout_hit && trigger)
                    timeout_error <= 1'b1;
            end
        end
    end

    // timestamp of the sampling edge
    always_ff @(posedge CLK)
    begin
        if (accept)
            ts_q <= ts_cnt;
    end

    // word decoded by the mode that was latched at acceptance
    always_comb
    begin
        evt_word = '0;
        if (mode_q == tlu_pkg::MODE_HANDSHAKE)
        begin
            evt_word.trg.valid  = 1'b1;
            evt_word.trg.number = rx_payload;
        end
        else
        begin
            evt_word.ts.valid = 1'b1;
            evt_word.ts.stamp = ts_q;
        end
    end

    // the buffer is drained before any new word arrives
    a_no_write_full: assert property (@(posedge CLK) disable iff (RESET)
        evt_write |-> !evt_full);

    a_start_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        start_flag |=> !start_flag);

    a_rx_start_handshake: assert property (@(posedge CLK) disable iff (RESET)
        rx_start |-> (mode_q == tlu_pkg::MODE_HANDSHAKE));

endmodule

// File: verilog/tlu_trigger_receiver.sv
`include "tlu_macros.svh"

module tlu_trigger_receiver (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      trigger,
    input  logic [4:0]                bit_count,
    input  logic                      msb_first,
    input  logic                      start,
    output logic                      tlu_clock,
    output logic                      done,
    output logic [`TLU_PAYLOAD_W-1:0] payload
);

    localparam int CYC_W = $clog2(`TLU_DIVISOR);
    localparam logic [CYC_W-1:0] MID_CYC  = CYC_W'(`TLU_DIVISOR / 2);
    localparam logic [CYC_W-1:0] LAST_CYC = CYC_W'(`TLU_DIVISOR - 1);

    logic [CYC_W-1:0] cyc_cnt;
    logic [4:0]       bit_cnt;
    logic [4:0]       nbits;
    logic             msb_q;
    logic [4:0]       bit_idx;

    // first bit lands on top of the number when msb first
    assign bit_idx = msb_q ? (nbits - 5'd1 - bit_cnt) : bit_cnt;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            tlu_clock <= 1'b0;
            done      <= 1'b0;
            cyc_cnt   <= '0;
            bit_cnt   <= 5'd0;
            nbits     <= 5'd0;
            msb_q     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                tlu_clock <= 1'b1;
                cyc_cnt   <= '0;
                bit_cnt   <= 5'd0;
                nbits     <= (bit_count == 5'd0) ? 5'(`TLU_BITS_DEFAULT) : bit_count;
                msb_q     <= msb_first;
            end
            else if (tlu_clock)
            begin
                if (cyc_cnt == LAST_CYC)
                begin
                    cyc_cnt <= '0;
                    bit_cnt <= bit_cnt + 5'd1;
                    if (bit_cnt == nbits - 5'd1)
                    begin
                        tlu_clock <= 1'b0;
                        done      <= 1'b1;
                    end
                end
                else
                begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                end
            end
        end
    end

    // midpoint sample, unused upper bits stay cleared
    always_ff @(posedge CLK)
    begin
        if (start)
            payload <= '0;
        else if (tlu_clock && (cyc_cnt == MID_CYC))
            payload[bit_idx] <= trigger;
    end

    a_no_restart: assert property (@(posedge CLK) disable iff (RESET)
        start |-> !tlu_clock);

endmodule

// File: verilog/tlu_event_wb.sv
module tlu_event_wb (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                write,
    input  tlu_pkg::tlu_event_t word,
    output logic                full,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    output logic                wb_ack,
    output tlu_pkg::tlu_event_t wb_dat
);

    tlu_pkg::tlu_event_t word_q;
    logic                req;
    logic                pop;

    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wb_ack <= 1'b0;
            full   <= 1'b0;
            pop    <= 1'b0;
        end
        else
        begin
            wb_ack <= req;
            // the word goes out only if it was there when the request came
            pop    <= req && !wb_we && full;
            if (write)
                full <= 1'b1;
            else if (wb_ack && pop)
                full <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (write)
            word_q <= word;
        // empty buffer reads back with the valid marker clear
        if (req && !wb_we)
            wb_dat <= full ? word_q : '0;
    end

    a_ack_single: assert property (@(posedge CLK) disable iff (RESET)
        wb_ack |=> !wb_ack);

endmodule

// File: verilog/tlu_controller.sv
`include "tlu_macros.svh"

module tlu_controller (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                trigger,
    input  tlu_pkg::tlu_mode_t  mode,
    input  logic [7:0]          low_timeout,
    input  logic [4:0]          bit_count,
    input  logic                msb_first,
    output logic                busy,
    output logic                tlu_clock,
    output logic                start_flag,
    output logic                timeout_error,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    output logic                wb_ack,
    output tlu_pkg::tlu_event_t wb_dat
);

    logic                      rx_start;
    logic                      rx_done;
    logic [`TLU_PAYLOAD_W-1:0] rx_payload;
    logic                      evt_write;
    tlu_pkg::tlu_event_t       evt_word;
    logic                      evt_full;

    tlu_sequencer i_sequencer (
        .CLK           (CLK),
        .RESET         (RESET),
        .trigger       (trigger),
        .mode          (mode),
        .low_timeout   (low_timeout),
        .busy          (busy),
        .start_flag    (start_flag),
        .timeout_error (timeout_error),
        .rx_start      (rx_start),
        .rx_done       (rx_done),
        .rx_payload    (rx_payload),
        .evt_write     (evt_write),
        .evt_word      (evt_word),
        .evt_full      (evt_full)
    );

    // serial trigger number in handshake mode
    tlu_trigger_receiver i_receiver (
        .CLK       (CLK),
        .RESET     (RESET),
        .trigger   (trigger),
        .bit_count (bit_count),
        .msb_first (msb_first),
        .start     (rx_start),
        .tlu_clock (tlu_clock),
        .done      (rx_done),
        .payload   (rx_payload)
    );

    tlu_event_wb i_event_wb (
        .CLK    (CLK),
        .RESET  (RESET),
        .write  (evt_write),
        .word   (evt_word),
        .full   (evt_full),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_ack (wb_ack),
        .wb_dat (wb_dat)
    );

endmodule

// File: tb/tlu_controller_tb.sv
`include "tlu_macros.svh"

module tlu_controller_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TRIG       = 40;
    localparam int HIGH_MAX       = 24;
    localparam int READ_DELAY_MAX = 15;
    localparam int WATCHDOG_CYC   = (NUM_TRIG + 1) *
        (HIGH_MAX + 32 * `TLU_DIVISOR + READ_DELAY_MAX + 20);

    logic                CLK;
    logic                RESET;
    logic                trigger;
    tlu_pkg::tlu_mode_t  mode;
    logic [7:0]          low_timeout;
    logic [4:0]          bit_count;
    logic                msb_first;
    logic                busy;
    logic                tlu_clock;
    logic                start_flag;
    logic                timeout_error;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic                wb_ack;
    tlu_pkg::tlu_event_t wb_dat;

    logic [15:0] lfsr_state = 16'd4478;
    int unsigned edge_cnt   = 0;
    int          start_seen = 0;
    int          clk_high   = 0;

    tlu_controller i_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .trigger       (trigger),
        .mode          (mode),
        .low_timeout   (low_timeout),
        .bit_count     (bit_count),
        .msb_first     (msb_first),
        .busy          (busy),
        .tlu_clock     (tlu_clock),
        .start_flag    (start_flag),
        .timeout_error (timeout_error),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_ack        (wb_ack),
        .wb_dat        (wb_dat)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // reset-free edges so far, reference for the timestamp
    always @(posedge CLK)
    begin
        if (!RESET)
            edge_cnt <= edge_cnt + 1;
    end

    // per-trigger counts, cleared by the stimulus on a rising edge
    always @(negedge CLK)
    begin
        if (start_flag)
            start_seen++;
        if (tlu_clock)
            clk_high++;
    end

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = galois_step(lfsr_state);
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_event(input tlu_pkg::tlu_event_t got,
                               input tlu_pkg::tlu_event_t exp, input string what);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s, got %h expected %h",
                               $time, what, got, exp));
    endtask

    task automatic check_flags(input logic exp_busy, input logic exp_tclk,
                               input logic exp_start, input logic exp_terr,
                               input string what);
        if ({busy, tlu_clock, start_flag, timeout_error} !==
            {exp_busy, exp_tclk, exp_start, exp_terr})
            fail_run($sformatf(
                "MISMATCH at %0t: %s, busy tlu_clock start timeout %b%b%b%b expected %b%b%b%b",
                $time, what, busy, tlu_clock, start_flag, timeout_error,
                exp_busy, exp_tclk, exp_start, exp_terr));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
            fail_run($sformatf("MISMATCH at %0t: %s, got %0d expected %0d",
                               $time, what, got, exp));
    endtask

    // classic read, returns on the cycle after ack
    task automatic host_read(output tlu_pkg::tlu_event_t word);
        int waited;
        waited = 0;
        @(posedge CLK);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        @(negedge CLK);
        while (!wb_ack)
        begin
            waited++;
            if (waited > 4)
                fail_run("the event buffer never acknowledged a read request");
            @(negedge CLK);
        end
        word = wb_dat;
        @(posedge CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge CLK);
        if (wb_ack)
            fail_run($sformatf("MISMATCH at %0t: wb_ack high for a second cycle", $time));
    endtask

    // TLU raises the line, checks the accept, then drops it
    task automatic send_trigger(input int high_cycles, output logic [`TLU_TS_W-1:0] ts);
        @(posedge CLK);
        trigger <= 1'b1;
        ts = `TLU_TS_W'(edge_cnt + 1);
        repeat (2) @(negedge CLK);
        check_flags(1'b1, 1'b0, 1'b1, 1'b0, "trigger accepted");
        repeat (high_cycles - 1) @(posedge CLK);
        trigger <= 1'b0;
    endtask

    // one bit per window, stable well around the midpoint
    task automatic send_number(input int nbits, input logic msb,
                               input logic [`TLU_PAYLOAD_W-1:0] number);
        int waited;
        waited = 0;
        @(negedge CLK);
        while (!tlu_clock)
        begin
            waited++;
            if (waited > 4)
                fail_run("tlu_clock did not start after the trigger line fell");
            @(negedge CLK);
        end
        @(posedge CLK);
        for (int b = 0; b < nbits; b++)
        begin
            trigger <= msb ? number[nbits-1-b] : number[b];
            repeat (`TLU_DIVISOR) @(posedge CLK);
        end
        trigger <= 1'b0;
    endtask

    initial
    begin
        repeat (WATCHDOG_CYC) @(posedge CLK);
        fail_run("timeout: the test sequence did not finish in time");
    end

    initial
    begin
        tlu_pkg::tlu_event_t           got;
        tlu_pkg::tlu_event_t           exp;
        logic [`TLU_TS_W-1:0]          ts;
        logic [`TLU_PAYLOAD_W-1:0]     number;
        logic                          exp_terr;
        logic                          hs;
        logic                          msb;
        int                            high;
        int                            nbits;
        int                            lt;

        RESET       = 1'b1;
        trigger     = 1'b0;
        mode        = tlu_pkg::MODE_TRIGGER;
        low_timeout = 8'd0;
        bit_count   = 5'd0;
        msb_first   = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        exp_terr    = 1'b0;
        repeat (8) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_flags(1'b0, 1'b0, 1'b0, 1'b0, "after reset");
        if (wb_ack)
            fail_run($sformatf("MISMATCH at %0t: wb_ack high after reset", $time));
        host_read(got);
        check_event(got, '0, "empty read after reset");

        for (int t = 0; t < NUM_TRIG; t++)
        begin
            @(posedge CLK);
            start_seen = 0;
            clk_high   = 0;
            hs    = take_bits(1);
            nbits = take_bits(5);
            // make sure the default bit count is seen once
            if (t == 1)
            begin
                hs    = 1'b1;
                nbits = 0;
            end
            msb  = take_bits(1);
            high = 2 + take_bits(4);
            lt   = 0;
            if (!hs && take_bits(1))
                lt = take_bits(4);
            mode        <= hs ? tlu_pkg::MODE_HANDSHAKE : tlu_pkg::MODE_TRIGGER;
            bit_count   <= 5'(nbits);
            msb_first   <= msb;
            low_timeout <= 8'(lt);
            if (nbits == 0)
                nbits = `TLU_BITS_DEFAULT;
            number = `TLU_PAYLOAD_W'(take_bits(nbits));

            send_trigger(high, ts);
            exp_terr = (lt != 0) && (lt < high);
            exp      = '0;
            if (hs)
            begin
                send_number(nbits, msb, number);
                exp.trg.valid  = 1'b1;
                exp.trg.number = number;
            end
            else
            begin
                exp.ts.valid = 1'b1;
                exp.ts.stamp = ts;
            end
            repeat (2) @(posedge CLK);
            check_count(clk_high, hs ? nbits * `TLU_DIVISOR : 0, "tlu_clock high cycles");
            @(negedge CLK);
            check_flags(1'b1, 1'b0, 1'b0, exp_terr, "word stored");

            // unread word must block a further trigger
            if (take_bits(1))
            begin
                @(posedge CLK);
                trigger <= 1'b1;
                repeat (4)
                begin
                    @(negedge CLK);
                    check_flags(1'b1, 1'b0, 1'b0, exp_terr, "trigger while word unread");
                end
                @(posedge CLK);
                trigger <= 1'b0;
            end

            repeat (take_bits(4)) @(posedge CLK);
            host_read(got);
            check_flags(1'b0, 1'b0, 1'b0, exp_terr, "cycle after read ack");
            check_event(got, exp, "event word");
            @(posedge CLK);
            check_count(start_seen, 1, "start_flag pulses");

            if (take_bits(1))
            begin
                host_read(got);
                check_event(got, '0, "empty read");
                check_flags(1'b0, 1'b0, 1'b0, exp_terr, "after empty read");
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/tlu_pkg.sv
verilog/tlu_sequencer.sv
verilog/tlu_trigger_receiver.sv
verilog/tlu_event_wb.sv
verilog/tlu_controller.sv
tb/tlu_controller_tb.sv

// File: Bender.yml
package:
  name: tlu_controller

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tlu_pkg.sv
      - verilog/tlu_sequencer.sv
      - verilog/tlu_trigger_receiver.sv
      - verilog/tlu_event_wb.sv
      - verilog/tlu_controller.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tlu_controller_tb.sv
